// ==== vlog.f ====
hw/spi_pkg.sv
hw/spi_peripheral.sv
hw/subperipheral_router.sv
hw/register_bank.sv
hw/byte_fifo.sv
hw/spi_subsystem.sv
testbench/clock_generator.sv
testbench/spi_subsystem_assertions.sv
testbench/spi_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: spi_subsystem

sources:
  - target: rtl
    files:
      - hw/spi_pkg.sv
      - hw/spi_peripheral.sv
      - hw/subperipheral_router.sv
      - hw/register_bank.sv
      - hw/byte_fifo.sv
      - hw/spi_subsystem.sv

  - target: test
    files:
      - testbench/clock_generator.sv
      - testbench/spi_subsystem_assertions.sv
      - testbench/spi_subsystem_tb.sv

// ==== testbench/spi_subsystem_tb.sv ====
// Testbench for the SPI bridge top level
// Transaction table built with a reference model of the scratch bytes and FIFO
// Mode 0 SPI master driver, typed compare tasks, watchdog

`default_nettype none

module spi_subsystem_tb import spi_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 8;
    localparam int gap_cycles = 8;
    localparam int max_bytes = 24;
    localparam int max_entries = 40;

    // Where the write bytes of an entry come from
    typedef enum int {
        fill_constant,
        fill_lfsr,
        fill_sequence
    } fill_t;

    // cut_bits of 0 sends every byte, otherwise select rises after that many bits
    typedef struct packed {
        logic [byte_width-1:0]                address;
        logic [7:0]                           byte_count;
        logic [7:0]                           cut_bits;
        logic [max_bytes-1:0][byte_width-1:0] write_bytes;
        logic [max_bytes-1:0][byte_width-1:0] read_bytes;
    } transaction_t;

    logic system_clock;
    logic arst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;

    transaction_t  transactions [max_entries];
    spi_response_t observed [max_bytes];
    int            entry_count;
    int            table_cycles;
    int            watchdog_cycles = 0;
    logic [7:0]    lfsr_state;

    // Reference state
    logic [byte_width-1:0] reference_scratch [scratch_count];
    logic [byte_width-1:0] reference_fifo [$];

    clock_generator clock_generator_i (
        .system_clock (system_clock),
        .arst_n       (arst_n)
    );

    spi_subsystem spi_subsystem_i (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [byte_width-1:0] draw_random_byte();
        logic [byte_width-1:0] value;
        value = '0;
        for (int b = 0; b < byte_width; b++) begin
            value = {value[byte_width-2:0], lfsr_state[7]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [byte_width-1:0] expected_read_value(input logic [7:0] address);
        logic [byte_width-1:0] value;
        value = '0;
        if (address == addr_identity) begin
            value = identity_value;
        end else if (address >= addr_scratch_base && address < addr_scratch_base + scratch_count) begin
            value = reference_scratch[int'(address) - int'(addr_scratch_base)];
        end else if (address == addr_fifo_pop && reference_fifo.size() > 0) begin
            value = reference_fifo[0];
        end else if (address == addr_fifo_count) begin
            value = byte_width'(reference_fifo.size());
        end
        return value;
    endfunction

    // Full FIFO drops pushes, empty FIFO ignores pops, unmapped writes vanish
    function automatic void update_reference(input logic [7:0] address, input logic [7:0] data);
        if (address >= addr_scratch_base && address < addr_scratch_base + scratch_count) begin
            reference_scratch[int'(address) - int'(addr_scratch_base)] = data;
        end else if (address == addr_fifo_push && reference_fifo.size() < fifo_depth) begin
            reference_fifo.push_back(data);
        end else if (address == addr_fifo_pop && reference_fifo.size() > 0) begin
            void'(reference_fifo.pop_front());
        end
    endfunction

    // Data bytes that reach their eighth rising edge before select rises
    function automatic int completed_bytes(input transaction_t entry);
        if (entry.cut_bits == 0) begin
            return int'(entry.byte_count);
        end
        return (entry.cut_bits > 8) ? (int'(entry.cut_bits) - 8) / 8 : 0;
    endfunction

    task automatic add_transaction(input logic [7:0] address, input int byte_count,
                                   input int cut_bits, input fill_t fill, input logic [7:0] base);
        transaction_t entry;
        int           completed;
        entry = '0;
        entry.address = address;
        entry.byte_count = 8'(byte_count);
        entry.cut_bits = 8'(cut_bits);
        completed = completed_bytes(entry);
        for (int i = 0; i < byte_count; i++) begin
            case (fill)
                fill_lfsr:     entry.write_bytes[i] = draw_random_byte();
                fill_sequence: entry.write_bytes[i] = base + 8'(i);
                default:       entry.write_bytes[i] = base;
            endcase
            // Each byte's read is captured before its own write lands
            if (i < completed) begin
                entry.read_bytes[i] = expected_read_value(address);
                update_reference(address, entry.write_bytes[i]);
            end
        end
        transactions[entry_count] = entry;
        entry_count++;
        table_cycles += 2 + 16 * (byte_count + 1) * half_period + half_period + gap_cycles;
    endtask

    task automatic build_table();
        // Identity on every byte, scratch zero after reset
        add_transaction(addr_identity, 4, 0, fill_constant, 8'hA5);
        for (int s = 0; s < scratch_count; s++) begin
            add_transaction(addr_scratch_base + 8'(s), 1, 0, fill_constant, 8'h00);
        end
        // LFSR bursts where the last byte of each burst stays
        for (int s = 0; s < scratch_count; s++) begin
            add_transaction(addr_scratch_base + 8'(s), 3, 0, fill_lfsr, 8'h00);
        end
        for (int s = 0; s < scratch_count; s++) begin
            add_transaction(addr_scratch_base + 8'(s), 2, 0, fill_lfsr, 8'h00);
        end
        // Stream of five, count, drain in order
        add_transaction(addr_fifo_push, 5, 0, fill_sequence, 8'h10);
        add_transaction(addr_fifo_count, 1, 0, fill_constant, 8'h00);
        add_transaction(addr_fifo_pop, 5, 0, fill_constant, 8'h00);
        // Overflow keeps 16, underflow reads zero
        add_transaction(addr_fifo_push, 20, 0, fill_sequence, 8'h40);
        add_transaction(addr_fifo_count, 1, 0, fill_constant, 8'h00);
        add_transaction(addr_fifo_pop, 18, 0, fill_constant, 8'h00);
        add_transaction(addr_fifo_count, 2, 0, fill_constant, 8'h00);
        // Unmapped addresses leave scratch and FIFO alone
        add_transaction(addr_fifo_push, 2, 0, fill_sequence, 8'hC0);
        add_transaction(8'h05, 3, 0, fill_lfsr, 8'h00);
        add_transaction(8'h7F, 2, 0, fill_lfsr, 8'h00);
        add_transaction(8'h20, 2, 0, fill_lfsr, 8'h00);
        add_transaction(addr_scratch_base + 8'd2, 2, 0, fill_lfsr, 8'h00);
        add_transaction(addr_scratch_base + 8'd3, 1, 0, fill_lfsr, 8'h00);
        add_transaction(addr_fifo_count, 1, 0, fill_constant, 8'h00);
        add_transaction(addr_fifo_pop, 2, 0, fill_constant, 8'h00);
        // Cut mid address, mid data byte, and after one pushed byte
        add_transaction(addr_scratch_base, 1, 5, fill_lfsr, 8'h00);
        add_transaction(addr_scratch_base + 8'd1, 1, 13, fill_lfsr, 8'h00);
        add_transaction(addr_fifo_push, 2, 19, fill_sequence, 8'hE0);
        add_transaction(addr_scratch_base + 8'd1, 2, 0, fill_lfsr, 8'h00);
        add_transaction(addr_scratch_base, 1, 0, fill_lfsr, 8'h00);
        add_transaction(addr_fifo_count, 1, 0, fill_constant, 8'h00);
        add_transaction(addr_fifo_pop, 2, 0, fill_constant, 8'h00);
        add_transaction(addr_identity, 2, 0, fill_constant, 8'h3C);
    endtask

    // Mode 0 master that changes data with the falling SPI edge
    task automatic run_transaction(input transaction_t entry);
        int                    bit_total;
        logic                  next_bit;
        logic [byte_width-1:0] shifted;
        bit_total = (entry.cut_bits != 0) ? int'(entry.cut_bits) : 8 * (int'(entry.byte_count) + 1);
        shifted = '0;
        @(posedge system_clock);
        spi_select <= 1'b0;
        spi_clock <= 1'b0;
        for (int j = 0; j < bit_total; j++) begin
            if (j < 8) begin
                next_bit = entry.address[7 - j];
            end else begin
                next_bit = entry.write_bytes[(j - 8) / 8][7 - ((j - 8) % 8)];
            end
            spi_data_in <= next_bit;
            repeat (half_period - 1) @(posedge system_clock);
            // MISO is settled mid-cycle, just ahead of the rising SPI edge
            @(negedge system_clock);
            shifted = {shifted[byte_width-2:0], spi_data_out};
            @(posedge system_clock);
            spi_clock <= 1'b1;
            repeat (half_period) @(posedge system_clock);
            spi_clock <= 1'b0;
            if (j >= 8 && (j % 8) == 7) begin
                observed[(j - 8) / 8].read_data = shifted;
            end
        end
        repeat (half_period) @(posedge system_clock);
        spi_select <= 1'b1;
        spi_data_in <= 1'b0;
        repeat (gap_cycles) @(posedge system_clock);
    endtask

    task automatic compare_read(input int entry_index, input int byte_index,
                                input spi_response_t actual, input spi_response_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf(
                "FAIL @ %0t ns: transaction %0d byte %0d read 0x%02h, expected 0x%02h",
                $time, entry_index, byte_index, actual.read_data, expected.read_data));
        end
    endtask

    task automatic compare_count(input int entry_index, input spi_response_t actual,
                                 input logic [fifo_count_width-1:0] expected);
        if (actual.read_data !== byte_width'(expected)) begin
            stop_with_failure($sformatf(
                "FAIL @ %0t ns: transaction %0d FIFO count %0d, expected %0d",
                $time, entry_index, actual.read_data, expected));
        end
    endtask

    // Budget is the whole table plus reset and margin
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge system_clock);
        stop_with_failure($sformatf(
            "Timeout: the run did not finish within %0d system clock cycles", watchdog_cycles));
    end

    // Failure flag of the bound checker
    initial begin
        wait (spi_subsystem_i.spi_peripheral_i.spi_subsystem_assertions_i.property_failed
              === 1'b1);
        stop_with_failure("A concurrent assertion on the peripheral request failed");
    end

    initial begin
        int completed;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data_in = 1'b0;
        lfsr_state = 8'd77;
        entry_count = 0;
        table_cycles = 0;
        for (int s = 0; s < scratch_count; s++) begin
            reference_scratch[s] = '0;
        end
        build_table();
        watchdog_cycles = table_cycles + 10 + 200;
        wait (arst_n === 1'b1);
        repeat (4) @(posedge system_clock);
        for (int e = 0; e < entry_count; e++) begin
            run_transaction(transactions[e]);
            completed = completed_bytes(transactions[e]);
            for (int i = 0; i < completed; i++) begin
                if (transactions[e].address == addr_fifo_count) begin
                    compare_count(e, observed[i],
                                  fifo_count_width'(transactions[e].read_bytes[i]));
                end else begin
                    compare_read(e, i, observed[i],
                                 spi_response_t'(transactions[e].read_bytes[i]));
                end
            end
        end
        if (spi_subsystem_i.spi_peripheral_i.spi_subsystem_assertions_i.property_failed) begin
            stop_with_failure("A concurrent assertion on the peripheral request failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/spi_subsystem_assertions.sv ====
// Protocol checks on the peripheral request and response structs
// Bound into every spi_peripheral instance

`default_nettype none

module spi_subsystem_assertions import spi_pkg::*; (
    input wire logic          system_clock,
    input wire logic          arst_n,
    input wire logic          stable_select,
    input wire spi_request_t  request,
    input wire spi_response_t response
);
    timeunit 1ns;
    timeprecision 100ps;

    // Raised by any failing property
    logic property_failed;

    initial begin
        property_failed = 1'b0;
    end

    // Data strobe lasts a single clock
    data_valid_single: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        request.data_valid |=> !request.data_valid
    ) else begin
        $error("data_valid stayed high for two clocks");
        property_failed = 1'b1;
    end

    // No data byte before the address is known
    data_after_address: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        $rose(request.data_valid) |-> request.address_valid
    ) else begin
        $error("data_valid rose without address_valid");
        property_failed = 1'b1;
    end

    // Deselect clears the address on the next clock
    address_cleared_on_select: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        stable_select |=> !request.address_valid
    ) else begin
        $error("address_valid high while select is high");
        property_failed = 1'b1;
    end

    // Read byte is always defined once an address is decoded
    response_known: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        request.address_valid |-> !$isunknown(response.read_data)
    ) else begin
        $error("read data unknown during a transaction");
        property_failed = 1'b1;
    end

endmodule

bind spi_peripheral spi_subsystem_assertions spi_subsystem_assertions_i (
    .system_clock  (system_clock),
    .arst_n        (arst_n),
    .stable_select (stable_select),
    .request       (request),
    .response      (response)
);

`default_nettype wire

// ==== testbench/clock_generator.sv ====
// System clock and power-on reset for the testbench
// 10 ns clock period, arst_n held low for the first 10 cycles

`default_nettype none

module clock_generator (
    output logic system_clock,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 10;

    initial begin
        system_clock = 1'b0;
        forever begin
            #5 system_clock = ~system_clock;
        end
    end

    // Release lands after the flops have sampled this edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge system_clock);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== hw/spi_subsystem.sv ====
// SPI bridge top level
// SPI peripheral, address router, register bank and byte FIFO

`default_nettype none

module spi_subsystem import spi_pkg::*; (
    input  wire logic system_clock,
    input  wire logic arst_n,
    input  wire logic spi_select,
    input  wire logic spi_clock,
    input  wire logic spi_data_in,
    output logic      spi_data_out
);

    // Peripheral side
    spi_request_t  request;
    spi_response_t response;

    // Target side
    spi_request_t          register_request;
    spi_request_t          fifo_request;
    logic                  fifo_pop;
    logic [byte_width-1:0] register_read;
    logic [byte_width-1:0] fifo_read;

    spi_peripheral spi_peripheral_i (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .request      (request),
        .response     (response)
    );

    subperipheral_router subperipheral_router_i (
        .system_clock     (system_clock),
        .arst_n           (arst_n),
        .request          (request),
        .response         (response),
        .register_request (register_request),
        .register_read    (register_read),
        .fifo_request     (fifo_request),
        .fifo_pop         (fifo_pop),
        .fifo_read        (fifo_read)
    );

    register_bank register_bank_i (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .request      (register_request),
        .read_data    (register_read)
    );

    byte_fifo byte_fifo_i (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .request      (fifo_request),
        .pop          (fifo_pop),
        .read_data    (fifo_read)
    );

endmodule

`default_nettype wire

// ==== hw/byte_fifo.sv ====
// FIFO subperipheral
// 16-entry circular byte buffer with read and write pointers
// Push and pop addresses plus a count readback address

`default_nettype none

module byte_fifo import spi_pkg::*; (
    input  wire logic         system_clock,
    input  wire logic         arst_n,
    input  wire spi_request_t request,
    input  wire logic         pop,
    output logic [byte_width-1:0] read_data
);

    logic [byte_width-1:0]         storage [fifo_depth];
    logic [fifo_pointer_width-1:0] write_pointer;
    logic [fifo_pointer_width-1:0] read_pointer;
    logic [fifo_count_width-1:0]   count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = (count == fifo_count_width'(fifo_depth));
    assign empty = (count == '0);

    // Overflowing pushes and underflowing pops are dropped
    assign do_push = request.data_valid && (request.address == addr_fifo_push) && !full;
    assign do_pop  = pop && !empty;

    // Data array
    always_ff @(posedge system_clock) begin
        if (do_push) begin
            storage[write_pointer] <= request.data;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (do_push) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (do_pop) begin
                read_pointer <= read_pointer + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head byte at the pop address, zero when empty
    always_comb begin
        case (request.address)
            addr_fifo_pop:   read_data = empty ? '0 : storage[read_pointer];
            addr_fifo_count: read_data = byte_width'(count);
            default:         read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/register_bank.sv ====
// Register subperipheral
// Read-only identity byte at address 0
// Four writable scratch bytes above it

`default_nettype none

module register_bank import spi_pkg::*; (
    input  wire logic         system_clock,
    input  wire logic         arst_n,
    input  wire spi_request_t request,
    output logic [byte_width-1:0] read_data
);

    logic [byte_width-1:0]          scratch [scratch_count];
    logic                           scratch_hit;
    logic [scratch_index_width-1:0] scratch_index;

    // Scratch window check and offset into the array
    assign scratch_hit = (request.address >= addr_scratch_base) &&
                         (request.address <= addr_scratch_last);
    assign scratch_index = scratch_index_width'(request.address - addr_scratch_base);

    // Writes land on the data strobe
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < scratch_count; i++) begin
                scratch[i] <= '0;
            end
        end else if (request.data_valid && scratch_hit) begin
            scratch[scratch_index] <= request.data;
        end
    end

    // Combinational readback of the addressed byte
    always_comb begin
        if (request.address == addr_identity) begin
            read_data = identity_value;
        end else if (scratch_hit) begin
            read_data = scratch[scratch_index];
        end else begin
            read_data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/subperipheral_router.sv ====
// Address decode and steering between the SPI peripheral and its targets
// Registered target select, per-target data strobes, FIFO pop strobe
// Read data multiplexer back to the peripheral

`default_nettype none

module subperipheral_router import spi_pkg::*; (
    input  wire logic                  system_clock,
    input  wire logic                  arst_n,
    input  wire spi_request_t          request,
    output spi_response_t              response,
    output spi_request_t               register_request,
    input  wire logic [byte_width-1:0] register_read,
    output spi_request_t               fifo_request,
    output logic                       fifo_pop,
    input  wire logic [byte_width-1:0] fifo_read
);

    subperipheral_select_t decoded_select;
    subperipheral_select_t target;

    // Address map decode
    always_comb begin
        if (request.address >= addr_identity && request.address <= addr_scratch_last) begin
            decoded_select = select_registers;
        end else if (request.address >= addr_fifo_push && request.address <= addr_fifo_count) begin
            decoded_select = select_fifo;
        end else begin
            decoded_select = select_none;
        end
    end

    // Follows the decode while the address is valid, idle between transactions
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            target <= select_none;
        end else if (request.address_valid) begin
            target <= decoded_select;
        end else begin
            target <= select_none;
        end
    end

    // Each target sees the request but only its own data strobe
    always_comb begin
        register_request            = request;
        register_request.data_valid = request.data_valid && (target == select_registers);
        fifo_request                = request;
        fifo_request.data_valid     = request.data_valid && (target == select_fifo);
    end

    assign fifo_pop = fifo_request.data_valid && (request.address == addr_fifo_pop);

    // Unmapped addresses read as zero
    always_comb begin
        case (target)
            select_registers: response.read_data = register_read;
            select_fifo:      response.read_data = fifo_read;
            default:          response.read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/spi_peripheral.sv ====
// SPI mode 0 slave front end
// Two-flop pin synchronizers and SPI clock edge detection
// Address and data byte assembly with a 15-to-0 bit index
// MISO shift register loaded from the subperipheral response

`default_nettype none

module spi_peripheral import spi_pkg::*; (
    input  wire logic          system_clock,
    input  wire logic          arst_n,
    input  wire logic          spi_select,
    input  wire logic          spi_clock,
    input  wire logic          spi_data_in,
    output logic               spi_data_out,
    output spi_request_t       request,
    input  wire spi_response_t response
);

    // First and second synchronizer stages
    logic meta_select;
    logic meta_clock;
    logic meta_data;
    logic stable_select;
    logic stable_clock;
    logic stable_data;
    logic last_clock;

    logic spi_rise;
    logic spi_fall;

    spi_phase_t phase;
    // 15..8 while receiving the address, then 7..0 for each data byte
    logic [3:0] bit_index;

    logic [byte_width-1:0] address_shift;
    logic [byte_width-1:0] data_shift;
    logic                  address_valid;
    logic                  data_valid;
    logic                  address_valid_q;
    logic                  capture_pending;
    logic [byte_width-1:0] miso_shift;

    // Select idles high so it resets to the inactive level
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            meta_select   <= 1'b1;
            meta_clock    <= 1'b0;
            meta_data     <= 1'b0;
            stable_select <= 1'b1;
            stable_clock  <= 1'b0;
            stable_data   <= 1'b0;
            last_clock    <= 1'b0;
        end else begin
            meta_select   <= spi_select;
            meta_clock    <= spi_clock;
            meta_data     <= spi_data_in;
            stable_select <= meta_select;
            stable_clock  <= meta_clock;
            stable_data   <= meta_data;
            last_clock    <= stable_clock;
        end
    end

    // SPI clock edges as seen after synchronization
    assign spi_rise = stable_clock & ~last_clock;
    assign spi_fall = ~stable_clock & last_clock;

    // Phase, bit index and the valid flags
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            phase         <= phase_idle;
            bit_index     <= 4'd15;
            address_valid <= 1'b0;
            data_valid    <= 1'b0;
        end else if (stable_select) begin
            // Select high aborts any partial byte
            phase         <= phase_idle;
            bit_index     <= 4'd15;
            address_valid <= 1'b0;
            data_valid    <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            if (phase == phase_idle) begin
                phase <= phase_address;
            end
            if (spi_rise) begin
                if (phase == phase_data) begin
                    if (bit_index == 4'd0) begin
                        data_valid <= 1'b1;
                    end
                end else if (bit_index == 4'd8) begin
                    // Address complete, everything after is data
                    address_valid <= 1'b1;
                    phase         <= phase_data;
                end
                // Roll back to 7 so data bytes repeat
                bit_index <= (bit_index == 4'd0) ? 4'd7 : bit_index - 4'd1;
            end
        end
    end

    // Byte assembly, MSB first
    // Address bits 15..8 map onto address[7:0] through the low index bits
    always_ff @(posedge system_clock) begin
        if (!stable_select && spi_rise) begin
            if (phase == phase_data) begin
                data_shift[bit_index[2:0]] <= stable_data;
            end else begin
                address_shift[bit_index[2:0]] <= stable_data;
            end
        end
    end

    // Response capture and MISO shifting
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            address_valid_q <= 1'b0;
            capture_pending <= 1'b0;
            miso_shift      <= '0;
        end else if (stable_select) begin
            address_valid_q <= 1'b0;
            capture_pending <= 1'b0;
            miso_shift      <= '0;
        end else begin
            address_valid_q <= address_valid;
            // One clock after the address arrives or a data byte is handed over
            capture_pending <= (address_valid & ~address_valid_q) | data_valid;
            if (capture_pending) begin
                miso_shift <= response.read_data;
            end else if (spi_fall && bit_index != 4'd7) begin
                // Falling edge after a byte's last bit keeps the freshly loaded MSB
                miso_shift <= {miso_shift[byte_width-2:0], 1'b0};
            end
        end
    end

    assign spi_data_out = miso_shift[byte_width-1] & ~spi_select;

    assign request.address       = address_shift;
    assign request.address_valid = address_valid;
    assign request.data          = data_shift;
    assign request.data_valid    = data_valid;

endmodule

`default_nettype wire

// ==== hw/spi_pkg.sv ====
// Shared definitions for the SPI bridge
// Byte and FIFO widths, subperipheral address map and identity constant
// Request and response structs, SPI phase and target select enums

`default_nettype none

package spi_pkg;

    // Word and FIFO sizing
    localparam int byte_width = 8;
    localparam int fifo_depth = 16;
    localparam int fifo_count_width = 5;
    localparam int fifo_pointer_width = $clog2(fifo_depth);

    // Scratch register bank sizing
    localparam int scratch_count = 4;
    localparam int scratch_index_width = $clog2(scratch_count);

    // Subperipheral address map
    localparam logic [byte_width-1:0] addr_identity = 8'h00;
    localparam logic [byte_width-1:0] addr_scratch_base = 8'h01;
    localparam logic [byte_width-1:0] addr_scratch_last =
        addr_scratch_base + byte_width'(scratch_count - 1);
    localparam logic [byte_width-1:0] addr_fifo_push = 8'h30;
    localparam logic [byte_width-1:0] addr_fifo_pop = 8'h31;
    localparam logic [byte_width-1:0] addr_fifo_count = 8'h32;

    // Constant returned at the identity address
    localparam logic [byte_width-1:0] identity_value = 8'h81;

    // Where the peripheral is within a transaction
    typedef enum logic [1:0] {
        phase_idle,
        phase_address,
        phase_data
    } spi_phase_t;

    // Which subperipheral the current address targets
    typedef enum logic [1:0] {
        select_none,
        select_registers,
        select_fifo
    } subperipheral_select_t;

    // Address is a level for the whole transaction, data_valid a single-clock strobe
    typedef struct packed {
        logic [byte_width-1:0] address;
        logic                  address_valid;
        logic [byte_width-1:0] data;
        logic                  data_valid;
    } spi_request_t;

    // Byte to shift out on MISO
    typedef struct packed {
        logic [byte_width-1:0] read_data;
    } spi_response_t;

endpackage

`default_nettype wire
